// ==== include/cam_params.svh ====
`ifndef CAM_PARAMS_SVH
`define CAM_PARAMS_SVH

// frame geometry
`define CAM_ROWS 34
`define CAM_COLS 26
`define CAM_FRAME_BYTES 884

// one pass is 34 row slots plus 10 idle gaps
`define CAM_SLOTS 44

`define CAM_SYNC 8'h5A

// reset values of the config registers
`define CAM_DIV_DEFAULT 16'd16
`define CAM_PASS_DEFAULT 2'd3

// smallest divisor that still leaves a usable mid-bit point
`define CAM_DIV_MIN 16'd4

`endif

// ==== hw/cam_pkg.sv ====
`include "cam_params.svh"

package cam_pkg;

  // byte 0 of the row sits in bits [7:0]
  typedef logic [`CAM_COLS*8-1:0] row_word_t;

  typedef struct packed {
    logic [15:0] baud_div;  // clocks per bit
    logic [1:0]  passes;    // 1 to 3
  } cam_cfg_t;

  typedef struct packed {
    logic        addr;  // 0 divisor, 1 passes
    logic [15:0] data;
  } cfg_wr_t;

  typedef struct packed {
    logic        busy;       // frame streaming
    logic        row_valid;
    logic [1:0]  pass;
    logic [5:0]  row;
    row_word_t   data;
  } cam_row_t;

endpackage

// ==== hw/cam_cfg_regs.sv ====
`timescale 1ns/1ps
`include "cam_params.svh"

module cam_cfg_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_wr_en,
  input  cam_pkg::cfg_wr_t   cfg_wr,
  output cam_pkg::cam_cfg_t  cfg
);

  logic [15:0] div_q;
  logic [1:0]  pass_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_q  <= `CAM_DIV_DEFAULT;
      pass_q <= `CAM_PASS_DEFAULT;
    end else if (cfg_wr_en) begin
      if (cfg_wr.addr) begin
        pass_q <= (cfg_wr.data[1:0] == 2'd0) ? 2'd1 : cfg_wr.data[1:0];  // 0 means one pass
      end else begin
        div_q <= (cfg_wr.data < `CAM_DIV_MIN) ? `CAM_DIV_MIN : cfg_wr.data;
      end
    end
  end

  assign cfg.baud_div = div_q;
  assign cfg.passes   = pass_q;

  // the stream controller relies on at least one pass
  a_passes_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    pass_q != 2'd0);

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps
`include "cam_params.svh"

module uart_rx (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  input  logic [15:0] baud_div,
  output logic [7:0]  rx_byte,
  output logic        rx_strobe
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} rx_state_t;

  rx_state_t   state;
  logic [2:0]  rx_sync;  // two sync flops plus one for edge history
  logic [15:0] div_q;    // divisor frozen for the whole byte
  logic [15:0] bit_cnt;
  logic [2:0]  bit_idx;
  logic [7:0]  shift;
  logic        rx_s;
  logic        start_edge;
  logic        half_done;
  logic        bit_done;

  assign rx_s       = rx_sync[1];
  assign start_edge = rx_sync[2] & ~rx_sync[1];
  assign half_done  = bit_cnt == ({1'b0, div_q[15:1]} - 16'd1);
  assign bit_done   = bit_cnt == (div_q - 16'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 3'b111;  // line idles high
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      div_q     <= `CAM_DIV_DEFAULT;
      bit_cnt   <= 16'd0;
      bit_idx   <= 3'd0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_edge) begin
            div_q   <= baud_div;  // new divisor only applies here
            bit_cnt <= 16'd0;
            state   <= S_START;
          end
        end
        S_START: begin
          if (half_done) begin
            bit_cnt <= 16'd0;
            bit_idx <= 3'd0;
            state   <= rx_s ? S_IDLE : S_DATA;  // high at mid-bit was a glitch
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
        S_DATA: begin
          if (bit_done) begin
            bit_cnt <= 16'd0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
        S_STOP: begin
          if (bit_done) begin
            state     <= S_IDLE;
            rx_strobe <= rx_s;  // low stop bit drops the byte
          end else begin
            bit_cnt <= bit_cnt + 16'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DATA && bit_done) begin
      shift <= {rx_s, shift[7:1]};  // lsb first
    end
    if (state == S_STOP && bit_done && rx_s) begin
      rx_byte <= shift;
    end
  end

  a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_strobe |=> !rx_strobe);

endmodule

// ==== hw/frame_ram.sv ====
`timescale 1ns/1ps
`include "cam_params.svh"

module frame_ram (
  input  logic                clk,
  input  logic                wr_en,
  input  logic [9:0]          wr_addr,
  input  logic [7:0]          wr_data,
  input  logic [5:0]          rd_row,
  output cam_pkg::row_word_t  rd_data
);

  cam_pkg::row_word_t mem [`CAM_ROWS];

  logic [5:0] wr_row;
  logic [4:0] wr_lane;

  // byte index split into row and byte lane
  assign wr_row  = 6'(wr_addr / `CAM_COLS);
  assign wr_lane = 5'(wr_addr % `CAM_COLS);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row][wr_lane*8 +: 8] <= wr_data;
    end
    rd_data <= mem[rd_row];  // whole row in one read
  end

endmodule

// ==== hw/cam_in.sv ====
`timescale 1ns/1ps
`include "cam_params.svh"

module cam_in (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          rx_byte,
  input  logic                rx_strobe,
  input  logic [1:0]          passes,
  output logic                wr_en,
  output logic [9:0]          wr_addr,
  output logic [7:0]          wr_data,
  output logic [5:0]          rd_row,
  input  cam_pkg::row_word_t  rd_data,
  output cam_pkg::cam_row_t   cam_out
);

  typedef enum logic [1:0] {ST_IDLE, ST_CAPTURE, ST_STREAM} ctl_state_t;

  ctl_state_t state;
  logic [7:0] prev_byte;
  logic [9:0] byte_cnt;
  logic [5:0] slot;      // slot whose row is being read
  logic [1:0] pass;
  logic [1:0] pass_lim;  // pass count latched per frame
  logic       sync_hit;
  logic       last_byte;
  logic       issue;
  logic       last_slot;
  logic       s1_busy;
  logic       s1_valid;
  logic [1:0] s1_pass;
  logic [5:0] s1_row;

  assign sync_hit  = rx_strobe && rx_byte == `CAM_SYNC && prev_byte == `CAM_SYNC;
  assign wr_en     = (state == ST_CAPTURE) && rx_strobe;
  assign wr_addr   = byte_cnt;
  assign wr_data   = rx_byte;
  assign last_byte = wr_en && byte_cnt == 10'(`CAM_FRAME_BYTES - 1);

  // slot 0 is read on the same edge that stores the last byte
  assign issue     = last_byte || state == ST_STREAM;
  assign last_slot = slot == 6'(`CAM_SLOTS - 1) && pass == pass_lim - 2'd1;
  assign rd_row    = (slot < 6'(`CAM_ROWS)) ? slot : 6'd0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      prev_byte <= 8'd0;
      byte_cnt  <= 10'd0;
      slot      <= 6'd0;
      pass      <= 2'd0;
      pass_lim  <= 2'd1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rx_strobe) begin
            prev_byte <= rx_byte;
          end
          if (sync_hit) begin
            state    <= ST_CAPTURE;  // sync pair itself is not stored
            byte_cnt <= 10'd0;
          end
        end
        ST_CAPTURE: begin
          if (wr_en) begin
            byte_cnt <= byte_cnt + 10'd1;
            if (last_byte) begin
              state    <= ST_STREAM;
              slot     <= 6'd1;
              pass     <= 2'd0;
              pass_lim <= passes;
            end
          end
        end
        ST_STREAM: begin
          if (last_slot) begin
            state     <= ST_IDLE;
            slot      <= 6'd0;
            pass      <= 2'd0;
            prev_byte <= 8'd0;  // sync search starts clean
          end else if (slot == 6'(`CAM_SLOTS - 1)) begin
            slot <= 6'd0;
            pass <= pass + 2'd1;
          end else begin
            slot <= slot + 6'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // stage 1 lines up with rd_data, stage 2 is the output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_busy  <= 1'b0;
      s1_valid <= 1'b0;
      s1_pass  <= 2'd0;
      s1_row   <= 6'd0;
      cam_out  <= '0;
    end else begin
      s1_busy           <= issue;
      s1_valid          <= issue && slot < 6'(`CAM_ROWS);
      s1_pass           <= pass;
      s1_row            <= slot;
      cam_out.busy      <= s1_busy;
      cam_out.row_valid <= s1_valid;
      cam_out.pass      <= s1_busy ? s1_pass : 2'd0;
      cam_out.row       <= s1_valid ? s1_row : 6'd0;
      cam_out.data      <= s1_valid ? rd_data : '0;  // gaps carry zero
    end
  end

  a_wr_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> wr_addr < 10'(`CAM_FRAME_BYTES));

  a_valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cam_out.row_valid |-> cam_out.busy);

endmodule

// ==== hw/cam_top.sv ====
`timescale 1ns/1ps

module cam_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  input  logic               cfg_wr_en,
  input  cam_pkg::cfg_wr_t   cfg_wr,
  output cam_pkg::cam_row_t  cam_out
);

  cam_pkg::cam_cfg_t  cfg;
  cam_pkg::row_word_t rd_data;
  logic [7:0]         rx_byte;
  logic               rx_strobe;
  logic               wr_en;
  logic [9:0]         wr_addr;
  logic [7:0]         wr_data;
  logic [5:0]         rd_row;

  cam_cfg_regs u_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_wr_en (cfg_wr_en),
    .cfg_wr    (cfg_wr),
    .cfg       (cfg)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .baud_div  (cfg.baud_div),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe)
  );

  cam_in u_ctl (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .passes    (cfg.passes),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_row    (rd_row),
    .rd_data   (rd_data),
    .cam_out   (cam_out)
  );

  frame_ram u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_row  (rd_row),
    .rd_data (rd_data)
  );

endmodule

// ==== verification/cam_tb.sv ====
`timescale 1ns/1ps
`include "cam_params.svh"

module cam_tb;

  localparam int CLK_NS = 10;
  localparam int NUM_TESTS = 5;

  // stimulus table, one column per field
  string       tab_name   [NUM_TESTS] = '{"div16_p3", "div8_p2", "div5_p1",
                                          "div4_p3_extra", "div8_p0"};
  int          tab_div    [NUM_TESTS] = '{16, 8, 5, 4, 8};
  int          tab_pass   [NUM_TESTS] = '{3, 2, 1, 3, 0};
  int          tab_exp    [NUM_TESTS] = '{3, 2, 1, 3, 1};  // a written 0 acts as 1
  logic [31:0] tab_noise  [NUM_TESTS] = '{32'h5A135AC3, 32'hFF5A0081, 32'h5AA55A3C,
                                          32'h11225A7E, 32'h5A5B5A01};
  bit          tab_extra  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

  logic              clk;
  logic              rst_n;
  logic              rx;
  logic              cfg_wr_en;
  cam_pkg::cfg_wr_t  cfg_wr;
  cam_pkg::cam_row_t cam_out;

  logic [7:0]  frame [`CAM_FRAME_BYTES];  // expected frame of the current test
  logic [15:0] lfsr_q = 16'd76;
  bit          last_started;
  int          errors;
  int          failed_tests;

  cam_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .cfg_wr_en (cfg_wr_en),
    .cfg_wr    (cfg_wr),
    .cam_out   (cam_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] next_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b = {b[6:0], lfsr_q[0]};  // one step per bit
    end
    return b;
  endfunction

  function automatic cam_pkg::row_word_t frame_row(input int r);
    cam_pkg::row_word_t w;
    w = '0;
    for (int c = 0; c < `CAM_COLS; c++) begin
      w[c*8 +: 8] = frame[r*`CAM_COLS + c];  // byte 0 lands in the low bits
    end
    return w;
  endfunction

  function automatic int bytes_for(input int t);
    return 4 + 2 + `CAM_FRAME_BYTES + (tab_extra[t] ? 2 : 0);
  endfunction

  // caller is on a falling edge
  task automatic send_byte(input logic [7:0] b, input int div);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};  // stop, data, start
    for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      repeat (div) @(negedge clk);
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [15:0] data);
    cfg_wr.addr = addr;
    cfg_wr.data = data;
    cfg_wr_en = 1'b1;
    @(negedge clk);
    cfg_wr_en = 1'b0;
  endtask

  task automatic check_row(input string name, input logic exp_valid,
                           input cam_pkg::row_word_t exp_data, input int slot,
                           input int exp_pass);
    if (cam_out.row_valid !== exp_valid) begin
      $display("[FAIL] %s: row_valid slot %0d pass %0d expected %0b actual %0b",
               name, slot, exp_pass, exp_valid, cam_out.row_valid);
      errors++;
    end
    if (exp_valid && int'(cam_out.row) != slot) begin
      $display("[FAIL] %s: row field expected %0d actual %0d", name, slot, cam_out.row);
      errors++;
    end
    if (int'(cam_out.pass) != exp_pass) begin
      $display("[FAIL] %s: pass field slot %0d expected %0d actual %0d",
               name, slot, exp_pass, cam_out.pass);
      errors++;
    end
    if (cam_out.data !== exp_data) begin
      $display("[FAIL] %s: data slot %0d pass %0d expected %h actual %h",
               name, slot, exp_pass, exp_data, cam_out.data);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    if (act != exp) begin
      $display("[FAIL] %s: %s expected %0d actual %0d", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic drive_frame(input int t);
    for (int i = 3; i >= 0; i--) begin
      send_byte(tab_noise[t][i*8 +: 8], tab_div[t]);
    end
    send_byte(`CAM_SYNC, tab_div[t]);
    send_byte(`CAM_SYNC, tab_div[t]);
    for (int k = 0; k < `CAM_FRAME_BYTES; k++) begin
      if (k == `CAM_FRAME_BYTES - 1) begin
        last_started = 1'b1;
      end
      send_byte(frame[k], tab_div[t]);
    end
    if (tab_extra[t]) begin
      send_byte(`CAM_SYNC, tab_div[t]);  // lands while streaming
      send_byte(`CAM_SYNC, tab_div[t]);
    end
  endtask

  task automatic collect_rows(input int t);
    int quiet_bad;
    int slots;
    int valid_rows;
    int s;
    quiet_bad = 0;
    slots = 0;
    valid_rows = 0;
    @(negedge clk);
    while (!cam_out.busy) begin
      if (cam_out.row_valid || cam_out.data != '0) begin
        quiet_bad++;
      end
      @(negedge clk);
    end
    if (!last_started) begin
      $display("%s: busy rose before the whole frame was sent", tab_name[t]);
      errors++;
    end
    while (cam_out.busy) begin
      s = slots % `CAM_SLOTS;
      if (cam_out.row_valid) begin
        valid_rows++;
      end
      if (s < `CAM_ROWS) begin
        check_row(tab_name[t], 1'b1, frame_row(s), s, slots / `CAM_SLOTS);
      end else begin
        check_row(tab_name[t], 1'b0, '0, s, slots / `CAM_SLOTS);  // idle gap
      end
      slots++;
      @(negedge clk);
    end
    check_count(tab_name[t], "active cycles before streaming", 0, quiet_bad);
    check_count(tab_name[t], "busy slots", tab_exp[t] * `CAM_SLOTS, slots);
    check_count(tab_name[t], "valid rows", tab_exp[t] * `CAM_ROWS, valid_rows);
  endtask

  task automatic run_test(input int t);
    int err_start;
    err_start = errors;
    last_started = 1'b0;
    write_cfg(1'b0, 16'(tab_div[t]));
    write_cfg(1'b1, 16'(tab_pass[t]));
    for (int k = 0; k < `CAM_FRAME_BYTES; k++) begin
      frame[k] = next_byte();
    end
    fork
      drive_frame(t);
      collect_rows(t);
    join
    if (errors == err_start) begin
      $display("test %s: passed", tab_name[t]);
    end else begin
      $display("test %s: %0d errors", tab_name[t], errors - err_start);
      failed_tests++;
    end
  endtask

  initial begin : watchdog
    int budget;
    budget = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      budget += bytes_for(t) * 10 * tab_div[t] + tab_exp[t] * `CAM_SLOTS;
    end
    budget = budget * 2;  // in clock cycles
    #(budget * CLK_NS);
    $display("watchdog: the run timed out after %0d cycles", budget);
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    errors = 0;
    failed_tests = 0;
    rx = 1'b1;  // line idles high
    cfg_wr_en = 1'b0;
    cfg_wr = '0;
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, tests failed %0d, check errors %0d",
             NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
hw/cam_pkg.sv
hw/cam_cfg_regs.sv
hw/uart_rx.sv
hw/frame_ram.sv
hw/cam_in.sv
hw/cam_top.sv
verification/cam_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module cam_tb -o cam_sim \
  && ./obj_dir/cam_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation PASSED"; exit 0; }
